// ==== build.f ====
+incdir+tests
rtl/noc_pkg.sv
rtl/route_compute.sv
rtl/input_channel.sv
rtl/switch_arbiter.sv
rtl/router_slice.sv
tests/tb_router_slice.sv

// ==== tests/tb_router_tasks.svh ====
`ifndef TB_ROUTER_TASKS_SVH
`define TB_ROUTER_TASKS_SVH

//////////////////////////////////////////////////
// stimulus and collection helpers
//////////////////////////////////////////////////

// step one clock and land just after the edge
task automatic tick();
   @(posedge clk);
   #1;
endtask

// upstream sender that holds off while the channel is busy
task automatic send_flit(input int c, input flit_t f);
   while (in_busy[c]) begin
      tick();
   end
   in_flit[c]  = f;
   in_valid[c] = 1'b1;
   tick();
   in_valid[c] = 1'b0;
endtask

// both channels strobe in the same cycle
task automatic strobe_both(input flit_t f0, input flit_t f1);
   in_flit[0]  = f0;
   in_flit[1]  = f1;
   in_valid[0] = 1'b1;
   in_valid[1] = 1'b1;
   tick();
   in_valid[0] = 1'b0;
   in_valid[1] = 1'b0;
endtask

// single flit to (dx, dy) with random filler in bits 5..4
function automatic flit_t single_to(input coord_t dx, input coord_t dy);
   logic [1:0] pad;
   pad = 2'($urandom);
   return {FLIT_SINGLE, pad, dy, dx};
endfunction

// x first then y and local when both match
function automatic int expected_port(input coord_t dx, input coord_t dy);
   if (dx > HERE_X)
      return PORT_E;
   if (dx < HERE_X)
      return PORT_W;
   // south is the growing y direction
   if (dy > HERE_Y)
      return PORT_S;
   if (dy < HERE_Y)
      return PORT_N;
   return PORT_L;
endfunction

task automatic report_mismatch(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
   errors++;
   $display("[ERROR] %s: expected %0h, actual %0h", test, expected, actual);
endtask

// step until some output fires and return edges taken with port and flit
task automatic wait_output(input string test, output int edges, output int port,
                           output flit_t f);
   edges = 0;
   port  = -1;
   f     = '0;
   do begin
      tick();
      edges++;
   end while ((out_valid === '0) && (edges < 20));
   // one flit leaves on one port only
   if ($countones(out_valid) > 1) begin
      errors++;
      $display("%s: several output ports fired for one flit", test);
   end
   // lowest hot port is the one recorded
   for (int p = NUM_PORTS - 1; p >= 0; p--) begin
      if (out_valid[p] === 1'b1) begin
         port = p;
         f    = out_flit[p];
      end
   end
   if (port < 0) begin
      errors++;
      $display("%s: no flit came out within 20 cycles", test);
   end
endtask

//////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////

task automatic reset_state(input string test);
   if (out_valid !== '0)
      report_mismatch(test, 0, out_valid);
   for (int c = 0; c < NUM_CH; c++) begin
      if (in_busy[c] !== 1'b0)
         report_mismatch(test, 0, in_busy[c]);
   end
endtask

// every destination through channel 0 with a fixed two edge latency
task automatic route_whole_mesh();
   flit_t f;
   flit_t got;
   int    edges;
   int    port;
   for (int y = 0; y < MESH_DIM; y++) begin
      for (int x = 0; x < MESH_DIM; x++) begin
         f = single_to(coord_t'(x), coord_t'(y));
         send_flit(0, f);
         wait_output("xy mesh", edges, port, got);
         // strobe edge plus the one just waited
         if (edges + 1 != 2)
            report_mismatch("xy mesh latency", 2, edges + 1);
         if (port != expected_port(coord_t'(x), coord_t'(y)))
            report_mismatch("xy mesh port", expected_port(coord_t'(x), coord_t'(y)), port);
         if (got !== f)
            report_mismatch("xy mesh flit", f, got);
      end
   end
endtask

task automatic parallel_channels();
   flit_t     f0;
   flit_t     f1;
   port_vec_t want;
   // east and north from (2,3)
   f0   = single_to(2'd3, 2'd3);
   f1   = single_to(2'd2, 2'd0);
   want = '0;
   want[PORT_E] = 1'b1;
   want[PORT_N] = 1'b1;
   strobe_both(f0, f1);
   tick();
   if (out_valid !== want)
      report_mismatch("parallel valid", want, out_valid);
   if (out_flit[PORT_E] !== f0)
      report_mismatch("parallel east flit", f0, out_flit[PORT_E]);
   if (out_flit[PORT_N] !== f1)
      report_mismatch("parallel north flit", f1, out_flit[PORT_N]);
endtask

// tie on east where first is the channel the pointer should favour
task automatic contend_same_port(input int first);
   flit_t f [NUM_CH];
   flit_t got;
   int    edges;
   int    port;
   f[0] = single_to(2'd3, 2'd1);
   f[1] = single_to(2'd3, 2'd2);
   strobe_both(f[0], f[1]);
   wait_output("round robin", edges, port, got);
   if (port != PORT_E)
      report_mismatch("round robin port", PORT_E, port);
   if (got !== f[first])
      report_mismatch("round robin winner", f[first], got);
   // loser still holds its flit
   if (in_busy[1 - first] !== 1'b1)
      report_mismatch("round robin busy held", 1, in_busy[1 - first]);
   wait_output("round robin", edges, port, got);
   if (port != PORT_E)
      report_mismatch("round robin port", PORT_E, port);
   if (got !== f[1 - first])
      report_mismatch("round robin loser", f[1 - first], got);
   if (in_busy[1 - first] !== 1'b0)
      report_mismatch("round robin busy freed", 0, in_busy[1 - first]);
endtask

task automatic wormhole_lock();
   flit_t pkt [4];
   flit_t lone;
   flit_t want;
   flit_t seen [$];
   pkt[0] = {FLIT_HEAD, 2'b01, 2'd3, 2'd3};
   // payload low bits would decode west or north on their own
   pkt[1] = {FLIT_BODY, 6'h10};
   pkt[2] = {FLIT_BODY, 6'h21};
   pkt[3] = {FLIT_TAIL, 6'h32};
   lone   = single_to(2'd3, 2'd0);
   fork
      begin
         for (int i = 0; i < 4; i++) begin
            send_flit(0, pkt[i]);
         end
      end
      begin
         // arrives while the packet owns east
         repeat (3) tick();
         send_flit(1, lone);
      end
      begin
         flit_t got;
         int    edges;
         int    port;
         repeat (5) begin
            wait_output("wormhole", edges, port, got);
            if (port != PORT_E)
               report_mismatch("wormhole port", PORT_E, port);
            seen.push_back(got);
         end
      end
   join
   for (int i = 0; i < 5; i++) begin
      want = (i < 4) ? pkt[i] : lone;
      if (seen[i] !== want)
         report_mismatch("wormhole order", want, seen[i]);
   end
endtask

task automatic random_traffic();
   flit_t  f;
   flit_t  got;
   coord_t dx;
   coord_t dy;
   int     c;
   int     edges;
   int     port;
   repeat (40) begin
      c  = $urandom_range(NUM_CH - 1, 0);
      dx = coord_t'($urandom_range(MESH_DIM - 1, 0));
      dy = coord_t'($urandom_range(MESH_DIM - 1, 0));
      f  = single_to(dx, dy);
      send_flit(c, f);
      wait_output("random", edges, port, got);
      if (port != expected_port(dx, dy))
         report_mismatch("random port", expected_port(dx, dy), port);
      if (got !== f)
         report_mismatch("random flit", f, got);
   end
endtask

`endif

// ==== tests/tb_router_slice.sv ====
module tb_router_slice;

   import noc_pkg::*;

   // about 300 cycles of tests, plenty of slack
   localparam int     CYCLE_LIMIT = 3000;
   localparam coord_t HERE_X      = 2'd2;
   localparam coord_t HERE_Y      = 2'd3;

   logic      clk;
   logic      rst;
   flit_t     in_flit  [NUM_CH];
   logic      in_valid [NUM_CH];
   logic      in_busy  [NUM_CH];
   port_vec_t out_valid;
   flit_t     out_flit [NUM_PORTS];

   int errors;
   int cycles;

   router_slice #(
      .CUR_X (HERE_X),
      .CUR_Y (HERE_Y)
   ) router_slice_i (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (in_flit),
      .in_valid  (in_valid),
      .in_busy   (in_busy),
      .out_valid (out_valid),
      .out_flit  (out_flit)
   );

   `include "tb_router_tasks.svh"

   // 4 unit period
   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: run stopped after %0d cycles", cycles);
         $display(">>> FAIL");
         $finish;
      end
   end

   initial begin
      void'($urandom(61));
      clk    = 1'b0;
      rst    = 1'b1;
      errors = 0;
      cycles = 0;
      for (int c = 0; c < NUM_CH; c++) begin
         in_flit[c]  = '0;
         in_valid[c] = 1'b0;
      end
      // 5 cycles of reset, outputs quiet throughout
      repeat (5) begin
         tick();
         reset_state("reset");
      end
      rst = 1'b0;
      tick();
      reset_state("after reset");
      route_whole_mesh();
      parallel_channels();
      // pointer on east starts at channel 0, then flips
      contend_same_port(0);
      contend_same_port(1);
      wormhole_lock();
      random_traffic();
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// ==== rtl/router_slice.sv ====
module router_slice #(
   parameter noc_pkg::coord_t CUR_X = 2'd2,
   parameter noc_pkg::coord_t CUR_Y = 2'd3
) (
   input  logic               clk,
   input  logic               rst,
   input  noc_pkg::flit_t     in_flit   [noc_pkg::NUM_CH],
   input  logic               in_valid  [noc_pkg::NUM_CH],
   output logic               in_busy   [noc_pkg::NUM_CH],
   output noc_pkg::port_vec_t out_valid,
   output noc_pkg::flit_t     out_flit  [noc_pkg::NUM_PORTS]
);

   import noc_pkg::*;

   // channel to arbiter
   logic      ch_req     [NUM_CH];
   flit_t     ch_flit    [NUM_CH];
   port_vec_t ch_route   [NUM_CH];
   logic      ch_is_tail [NUM_CH];
   logic      ch_grant   [NUM_CH];

   // one input channel per upstream link
   for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
      input_channel #(
         .CUR_X (CUR_X),
         .CUR_Y (CUR_Y)
      ) input_channel_i (
         .clk        (clk),
         .rst        (rst),
         .in_flit    (in_flit[c]),
         .in_valid   (in_valid[c]),
         .in_busy    (in_busy[c]),
         .ch_req     (ch_req[c]),
         .ch_flit    (ch_flit[c]),
         .ch_route   (ch_route[c]),
         .ch_is_tail (ch_is_tail[c]),
         .ch_grant   (ch_grant[c])
      );
   end

   switch_arbiter switch_arbiter_i (
      .clk        (clk),
      .rst        (rst),
      .ch_req     (ch_req),
      .ch_flit    (ch_flit),
      .ch_route   (ch_route),
      .ch_is_tail (ch_is_tail),
      .ch_grant   (ch_grant),
      .out_valid  (out_valid),
      .out_flit   (out_flit)
   );

endmodule

// ==== rtl/switch_arbiter.sv ====
module switch_arbiter (
   input  logic               clk,
   input  logic               rst,
   // from the input channels
   input  logic               ch_req     [noc_pkg::NUM_CH],
   input  noc_pkg::flit_t     ch_flit    [noc_pkg::NUM_CH],
   input  noc_pkg::port_vec_t ch_route   [noc_pkg::NUM_CH],
   input  logic               ch_is_tail [noc_pkg::NUM_CH],
   output logic               ch_grant   [noc_pkg::NUM_CH],
   // registered outputs, one per port
   output noc_pkg::port_vec_t out_valid,
   output noc_pkg::flit_t     out_flit   [noc_pkg::NUM_PORTS]
);

   import noc_pkg::*;

   // per port ownership for wormhole switching
   typedef enum logic [1:0] {
      LOCK_FREE = 2'b00,
      LOCK_CH0  = 2'b01,
      LOCK_CH1  = 2'b10
   } lock_e;

   lock_e               lock_q   [NUM_PORTS];
   // round robin pointer, channel that wins the next tie
   logic [NUM_PORTS-1:0] rr_q;

   // requests seen by each port
   logic [NUM_CH-1:0]   port_req [NUM_PORTS];
   // grants issued by each port
   logic [NUM_CH-1:0]   port_gnt [NUM_PORTS];
   // channel selected by each port, also the crossbar select
   logic                port_sel [NUM_PORTS];

   //////////////////////////////////////////////////
   // request matrix
   //////////////////////////////////////////////////

   always_comb begin
      for (int p = 0; p < NUM_PORTS; p++) begin
         for (int c = 0; c < NUM_CH; c++) begin
            port_req[p][c] = ch_req[c] && ch_route[c][p];
         end
      end
   end

   //////////////////////////////////////////////////
   // arbitration per output port
   //////////////////////////////////////////////////

   always_comb begin
      for (int p = 0; p < NUM_PORTS; p++) begin
         port_gnt[p] = '0;
         port_sel[p] = 1'b0;
         case (lock_q[p])
            LOCK_FREE: begin
               // tie goes to the pointer
               if (&port_req[p]) begin
                  port_sel[p] = rr_q[p];
               end else begin
                  port_sel[p] = port_req[p][1];
               end
               port_gnt[p][port_sel[p]] = |port_req[p];
            end
            // packet in flight, owner only
            LOCK_CH0: begin
               port_gnt[p][0] = port_req[p][0];
            end
            LOCK_CH1: begin
               port_sel[p]    = 1'b1;
               port_gnt[p][1] = port_req[p][1];
            end
            default: begin
               port_gnt[p] = '0;
            end
         endcase
      end
   end

   // each channel asks for one port, so at most one grant per channel
   always_comb begin
      for (int c = 0; c < NUM_CH; c++) begin
         ch_grant[c] = 1'b0;
         for (int p = 0; p < NUM_PORTS; p++) begin
            ch_grant[c] = ch_grant[c] | port_gnt[p][c];
         end
      end
   end

   //////////////////////////////////////////////////
   // lock, pointer and output valid
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int p = 0; p < NUM_PORTS; p++) begin
            lock_q[p] <= LOCK_FREE;
         end
         rr_q      <= '0;
         out_valid <= '0;
      end else begin
         for (int p = 0; p < NUM_PORTS; p++) begin
            out_valid[p] <= |port_gnt[p];
            if (|port_gnt[p]) begin
               // tail releases the port, anything else holds it
               if (ch_is_tail[port_sel[p]]) begin
                  lock_q[p] <= LOCK_FREE;
               end else begin
                  lock_q[p] <= port_sel[p] ? LOCK_CH1 : LOCK_CH0;
               end
            end
            // pointer moves only after a tie
            if ((lock_q[p] == LOCK_FREE) && (&port_req[p])) begin
               rr_q[p] <= ~rr_q[p];
            end
         end
      end
   end

   // crossbar into the output flit registers
   always_ff @(posedge clk) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
         if (|port_gnt[p]) begin
            out_flit[p] <= ch_flit[port_sel[p]];
         end
      end
   end

endmodule

// ==== rtl/input_channel.sv ====
module input_channel #(
   parameter noc_pkg::coord_t CUR_X = 2'd2,
   parameter noc_pkg::coord_t CUR_Y = 2'd3
) (
   input  logic               clk,
   input  logic               rst,
   // upstream side
   input  noc_pkg::flit_t     in_flit,
   input  logic               in_valid,
   output logic               in_busy,
   // arbiter side
   output logic               ch_req,
   output noc_pkg::flit_t     ch_flit,
   output noc_pkg::port_vec_t ch_route,
   output logic               ch_is_tail,
   input  logic               ch_grant
);

   import noc_pkg::*;

   // holding register state
   logic      busy_q;
   flit_t     flit_q;

   // route of the packet in flight
   port_vec_t route_q;

   // decoded fields of the held flit
   flit_kind_e kind;
   logic       is_head;
   coord_t     dest_x;
   coord_t     dest_y;
   port_vec_t  head_route;

   //////////////////////////////////////////////////
   // flit register
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         busy_q <= 1'b0;
      end else if (ch_grant) begin
         // flit left for the output register
         busy_q <= 1'b0;
      end else if (in_valid && !busy_q) begin
         busy_q <= 1'b1;
      end
   end

   // flit data taken on an accepted strobe
   always_ff @(posedge clk) begin
      if (in_valid && !busy_q) begin
         flit_q <= in_flit;
      end
   end

   //////////////////////////////////////////////////
   // decode and route
   //////////////////////////////////////////////////

   assign kind = flit_kind_e'(flit_q[FLIT_TYPE_LSB +: 2]);

   assign is_head    = (kind == FLIT_HEAD) || (kind == FLIT_SINGLE);
   assign ch_is_tail = (kind == FLIT_TAIL) || (kind == FLIT_SINGLE);

   // only meaningful on head flits
   assign dest_x = flit_q[DEST_X_LSB +: $bits(coord_t)];
   assign dest_y = flit_q[DEST_Y_LSB +: $bits(coord_t)];

   route_compute #(
      .CUR_X (CUR_X),
      .CUR_Y (CUR_Y)
   ) route_compute_i (
      .dest_x (dest_x),
      .dest_y (dest_y),
      .route  (head_route)
   );

   // keep the head's route for body and tail flits
   always_ff @(posedge clk) begin
      if (rst) begin
         route_q <= '0;
      end else if (ch_grant && is_head) begin
         route_q <= head_route;
      end
   end

   // fresh route on a head, stored one otherwise
   assign ch_route = is_head ? head_route : route_q;

   assign ch_flit = flit_q;
   assign ch_req  = busy_q;
   assign in_busy = busy_q;

endmodule

// ==== rtl/route_compute.sv ====
module route_compute #(
   parameter noc_pkg::coord_t CUR_X = 2'd2,
   parameter noc_pkg::coord_t CUR_Y = 2'd3
) (
   input  noc_pkg::coord_t    dest_x,
   input  noc_pkg::coord_t    dest_y,
   output noc_pkg::port_vec_t route
);

   import noc_pkg::*;

   // one bit wider than a coordinate so the difference keeps its sign
   localparam int DIFF_W = $clog2(MESH_DIM) + 1;

   // zero extended coordinates
   logic signed [DIFF_W-1:0] x_dst;
   logic signed [DIFF_W-1:0] y_dst;
   logic signed [DIFF_W-1:0] x_cur;
   logic signed [DIFF_W-1:0] y_cur;

   // destination minus current
   logic signed [DIFF_W-1:0] x_diff;
   logic signed [DIFF_W-1:0] y_diff;

   assign x_dst = DIFF_W'(dest_x);
   assign y_dst = DIFF_W'(dest_y);
   assign x_cur = DIFF_W'(CUR_X);
   assign y_cur = DIFF_W'(CUR_Y);

   assign x_diff = x_dst - x_cur;
   assign y_diff = y_dst - y_cur;

   //////////////////////////////////////////////////
   // dimension order routing, x first then y
   //////////////////////////////////////////////////

   always_comb begin
      route = '0;
      // x not yet reached
      if (x_diff > 0) begin
         route[PORT_E] = 1'b1;
      end else if (x_diff < 0) begin
         route[PORT_W] = 1'b1;
      // column reached, now fix y
      end else if (y_diff > 0) begin
         // y grows southwards
         route[PORT_S] = 1'b1;
      end else if (y_diff < 0) begin
         route[PORT_N] = 1'b1;
      end else begin
         // both match, eject here
         route[PORT_L] = 1'b1;
      end
   end

endmodule

// ==== rtl/noc_pkg.sv ====
package noc_pkg;

   //////////////////////////////////////////////////
   // mesh geometry
   //////////////////////////////////////////////////

   // nodes per dimension, 4x4 mesh
   localparam int MESH_DIM = 4;

   // one mesh coordinate
   typedef logic [1:0] coord_t;

   //////////////////////////////////////////////////
   // flit format
   //////////////////////////////////////////////////

   // 8 bit flit, type in the top two bits
   typedef logic [7:0] flit_t;

   // flit type field
   typedef enum logic [1:0] {
      FLIT_BODY   = 2'b00,
      FLIT_TAIL   = 2'b01,
      FLIT_HEAD   = 2'b10,
      // head and tail in one flit
      FLIT_SINGLE = 2'b11
   } flit_kind_e;

   // field positions
   localparam int FLIT_TYPE_LSB = 6;
   localparam int DEST_Y_LSB    = 2;
   localparam int DEST_X_LSB    = 0;

   //////////////////////////////////////////////////
   // ports and channels
   //////////////////////////////////////////////////

   // one-hot output port request
   typedef logic [4:0] port_vec_t;

   // bit index per output port
   localparam int PORT_L = 0;
   localparam int PORT_E = 1;
   localparam int PORT_W = 2;
   localparam int PORT_S = 3;
   localparam int PORT_N = 4;

   localparam int NUM_PORTS = 5;
   localparam int NUM_CH    = 2;

endpackage
